// ==== Bender.yml ====
package:
  name: sound_out

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/audio_pkg.sv
      - src/dac_timing_pkg.sv
      - src/i2s_clock_gen.sv
      - src/i2s_serializer.sv
      - src/pdm_modulator.sv
      - src/sound_out_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/sound_out_checker.sv
      - tests/tb_sound_out.sv

// ==== src/audio_pkg.sv ====
`include "sound_cfg.svh"

// Sample formats shared by the I2S and PDM paths
package audio_pkg;

    // One audio sample, two's complement
    typedef logic signed [`SOUND_SAMPLE_WIDTH-1:0] sample_t;

    // Stereo pair
    // Left is the first field, so it sits in the upper half
    // and leaves the serializer first
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    // PDM accumulator
    // Low bits hold the running remainder, top bit is the carry
    // that becomes the 1-bit output
    typedef logic [`SOUND_SAMPLE_WIDTH:0] pdm_acc_t;

endpackage

// ==== src/dac_timing_pkg.sv ====
`include "sound_cfg.svh"

// Counter and state types of the DAC timing logic
package dac_timing_pkg;

    // Bit position inside one channel word, 0 .. width-1
    typedef logic [$clog2(`SOUND_SAMPLE_WIDTH)-1:0] bit_index_t;

    // Half-period counter of the bit clock
    // One extra value of headroom so a ratio of 1 still gets a bit
    typedef logic [$clog2(`SOUND_BCLK_DIV+1)-1:0] bclk_count_t;

    // PDM step enable counter
    typedef logic [$clog2(`SOUND_DAC_FREQ_DIV+1)-1:0] dac_count_t;

    // Frame sequencer state
    // Encoding is the LRCLK level: low for left, high for right
    typedef enum logic {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_e;

endpackage

// ==== src/i2s_clock_gen.sv ====
`timescale 1ns/1ps
`include "sound_cfg.svh"

module i2s_clock_gen (
    input  logic DAC_BCLK_SRC,
    input  logic RESET_n,
    output logic bclk,
    output logic lrclk,
    output logic bclk_fall,
    output logic frame_start
);

    // Reload values, counters run down to zero
    localparam dac_timing_pkg::bclk_count_t bclk_reload =
        dac_timing_pkg::bclk_count_t'(`SOUND_BCLK_DIV - 1);
    localparam dac_timing_pkg::bit_index_t last_bit_idx =
        dac_timing_pkg::bit_index_t'(`SOUND_SAMPLE_WIDTH - 1);

    dac_timing_pkg::bclk_count_t bclk_cnt;
    dac_timing_pkg::bit_index_t  bit_idx;
    dac_timing_pkg::channel_e    channel;
    logic                        half_done;
    logic                        last_bit;

    // Terminal count of the half period
    assign half_done = (bclk_cnt == '0);

    // Bit clock is high and toggles at the next edge
    // so this cycle is the one in which it goes low
    assign bclk_fall = half_done & bclk;

    // Last bit of the current word
    assign last_bit = (bit_idx == last_bit_idx);

    // First fall after entering the left word
    // LRCLK went low one bit period earlier
    assign frame_start = bclk_fall && (channel == dac_timing_pkg::CH_LEFT)
                         && (bit_idx == '0);

    // State encoding is the pin level
    assign lrclk = (channel == dac_timing_pkg::CH_RIGHT);

    // Half-period counter
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            bclk_cnt <= bclk_reload;
        end else if (half_done) begin
            bclk_cnt <= bclk_reload;
        end else begin
            bclk_cnt <= bclk_cnt - 1'b1;
        end
    end

    // Bit clock, idles low out of reset
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            bclk <= 1'b0;
        end else if (half_done) begin
            bclk <= ~bclk;
        end
    end

    // Frame sequencer
    // Starts in the right word so the first LRCLK edge is a fall
    // Channel flips on the fall that carries the last bit,
    // i.e. one bit period ahead of the next MSB
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            bit_idx <= '0;
            channel <= dac_timing_pkg::CH_RIGHT;
        end else if (bclk_fall) begin
            if (last_bit) begin
                bit_idx <= '0;
                channel <= (channel == dac_timing_pkg::CH_LEFT) ?
                           dac_timing_pkg::CH_RIGHT : dac_timing_pkg::CH_LEFT;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

endmodule

// ==== src/i2s_serializer.sv ====
`timescale 1ns/1ps
`include "sound_cfg.svh"

module i2s_serializer (
    input  logic                      DAC_BCLK_SRC,
    input  logic                      RESET_n,
    input  logic                      sample_valid,
    input  audio_pkg::stereo_sample_t stereo_in,
    input  logic                      bclk_fall,
    input  logic                      frame_start,
    output logic                      din
);

    // Left and right words back to back
    localparam int frame_bits = 2 * `SOUND_SAMPLE_WIDTH;

    audio_pkg::stereo_sample_t held;
    logic [frame_bits-1:0]     shift_reg;
    logic [frame_bits-1:0]     frame_word;
    logic                      shift_en;

    // Held pair as one frame, left word on top
    assign frame_word = {held.left, held.right};

    // Every fall except the one that reloads
    assign shift_en = bclk_fall & ~frame_start;

    // Holding register
    // Latest strobe wins, no back-pressure toward the source
    // Without a new strobe the same pair is replayed every frame
    // Cleared so a frame before the first sample sends silence
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            held <= '0;
        end else if (sample_valid) begin
            held <= stereo_in;
        end
    end

    // Frame shift register
    // frame_start loads the pair and puts the left MSB on the pin
    // Each later fall moves the next bit up, zero fill behind
    // Left LSB goes out on the fall that flips LRCLK high,
    // right MSB on the fall after, matching I2S one-bit delay
    // Pin changes only on a falling bit-clock edge,
    // so data is settled at every rising edge
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            shift_reg <= '0;
        end else if (frame_start) begin
            shift_reg <= frame_word;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[frame_bits-2:0], 1'b0};
        end
    end

    // MSB first
    assign din = shift_reg[frame_bits-1];

endmodule

// ==== src/pdm_modulator.sv ====
`timescale 1ns/1ps
`include "sound_cfg.svh"

module pdm_modulator (
    input  logic               DAC_BCLK_SRC,
    input  logic               RESET_n,
    input  audio_pkg::sample_t sample,
    output logic               pdm_out
);

    // Step enable reload, counter runs down to zero
    localparam dac_timing_pkg::dac_count_t dac_reload =
        dac_timing_pkg::dac_count_t'(`SOUND_DAC_FREQ_DIV - 1);

    dac_timing_pkg::dac_count_t dac_cnt;
    logic                       step_en;
    audio_pkg::pdm_acc_t        offset_ext;
    audio_pkg::pdm_acc_t        acc;
    audio_pkg::pdm_acc_t        acc_next;

    // One pulse every div cycles
    assign step_en = (dac_cnt == '0);

    // Step enable divider
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            dac_cnt <= dac_reload;
        end else if (step_en) begin
            dac_cnt <= dac_reload;
        end else begin
            dac_cnt <= dac_cnt - 1'b1;
        end
    end

    // Offset binary
    // Sign bit inverted, negative full scale -> 0, positive -> all ones
    assign offset_ext = {1'b0, ~sample[`SOUND_SAMPLE_WIDTH-1],
                         sample[`SOUND_SAMPLE_WIDTH-2:0]};

    // Old carry dropped, remainder plus new sample
    assign acc_next = {1'b0, acc[`SOUND_SAMPLE_WIDTH-1:0]} + offset_ext;

    // First-order delta-sigma accumulator
    // Updated only on the step enable, holds in between
    always_ff @(posedge DAC_BCLK_SRC or negedge RESET_n) begin
        if (!RESET_n) begin
            acc <= '0;
        end else if (step_en) begin
            acc <= acc_next;
        end
    end

    // Registered carry, one cycle behind the enable
    // Density of ones = offset sample / 2^width
    assign pdm_out = acc[`SOUND_SAMPLE_WIDTH];

endmodule

// ==== src/sound_cfg.svh ====
`ifndef SOUND_CFG_SVH
`define SOUND_CFG_SVH

// Bits per audio sample, two's complement
// Also the number of bit-clock periods in one channel word
`define SOUND_SAMPLE_WIDTH 16

// DAC_BCLK_SRC cycles per half period of the I2S bit clock
// Bit clock = DAC_BCLK_SRC / (2 * div)
`define SOUND_BCLK_DIV 4

// DAC_BCLK_SRC cycles per PDM step
// Sets the oversampling rate of the internal sound pin
`define SOUND_DAC_FREQ_DIV 5

`endif

// ==== src/sound_out_top.sv ====
`timescale 1ns/1ps

module sound_out_top (
    input  logic                      DAC_BCLK_SRC,
    input  logic                      RESET_n,
    input  logic                      sample_valid,
    input  audio_pkg::stereo_sample_t stereo_in,
    input  audio_pkg::sample_t        mono_in,
    output logic                      i2s_bclk,
    output logic                      i2s_lrclk,
    output logic                      i2s_din,
    output logic                      sound_int
);

    // Timing strobes from the frame sequencer
    logic bclk_fall;
    logic frame_start;

    // Bit clock and LRCLK framing
    i2s_clock_gen u_clock_gen (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .bclk         (i2s_bclk),
        .lrclk        (i2s_lrclk),
        .bclk_fall    (bclk_fall),
        .frame_start  (frame_start)
    );

    // External stereo, always I2S
    i2s_serializer u_serializer (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .sample_valid (sample_valid),
        .stereo_in    (stereo_in),
        .bclk_fall    (bclk_fall),
        .frame_start  (frame_start),
        .din          (i2s_din)
    );

    // Cartridge internal sound pin
    // Runs on its own step enable, not tied to the I2S frame
    pdm_modulator u_pdm (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .sample       (mono_in),
        .pdm_out      (sound_int)
    );

endmodule

// ==== tb.f ====
+incdir+src
src/audio_pkg.sv
src/dac_timing_pkg.sv
src/i2s_clock_gen.sv
src/i2s_serializer.sv
src/pdm_modulator.sv
src/sound_out_top.sv
tests/sound_out_checker.sv
tests/tb_sound_out.sv

// ==== tests/sound_out_checker.sv ====
`timescale 1ns/1ps
`include "sound_cfg.svh"

module sound_out_checker (
    input  logic                      DAC_BCLK_SRC,
    input  logic                      RESET_n,
    input  logic                      i2s_bclk,
    input  logic                      i2s_lrclk,
    input  logic                      i2s_din,
    input  logic                      sound_int,
    input  logic                      expect_load,
    input  audio_pkg::stereo_sample_t exp_pair,
    input  int                        exp_offset,
    output logic                      window_done,
    output int                        pin_errors,
    output int                        word_errors,
    output int                        pdm_errors
);

    localparam int width        = `SOUND_SAMPLE_WIDTH;
    localparam int half_cycles  = `SOUND_BCLK_DIV;
    localparam int step_cycles  = `SOUND_DAC_FREQ_DIV;
    localparam int window_steps = 1024;
    localparam int full_scale   = 1 << width;

    // Pin levels seen at the previous clock
    logic bclk_q;
    logic lrclk_q;
    logic lr_at_rise;
    logic rst_seen;
    logic armed;

    // I2S decoder
    logic [width-1:0] word_sr;
    logic [width-1:0] word;
    int               run_len;
    int               falls_in_word;
    int               fall_cnt;
    int               frames_checked;

    // PDM density window
    int pdm_phase;
    int pdm_steps;
    int ones;
    int diff;

    // Expected values of the current row
    audio_pkg::stereo_sample_t exp_q;
    int                        exp_offset_q;

    logic bclk_rise;
    logic bclk_fell;
    logic lr_changed;
    logic lr_fell;

    assign bclk_rise  = i2s_bclk & ~bclk_q;
    assign bclk_fell  = ~i2s_bclk & bclk_q;
    assign lr_changed = i2s_lrclk ^ lrclk_q;
    assign lr_fell    = lrclk_q & ~i2s_lrclk;
    // Shift history plus the bit on the pin now
    assign word = {word_sr[width-2:0], i2s_din};

    initial begin
        pin_errors  = 0;
        word_errors = 0;
        pdm_errors  = 0;
    end

    // All pins sampled at the clock edge, before the DUT updates them
    always @(posedge DAC_BCLK_SRC) begin
        if (!RESET_n) begin
            // Idle levels while reset is held
            if (rst_seen && (i2s_bclk !== 1'b0 || i2s_lrclk !== 1'b1 ||
                             i2s_din !== 1'b0 || sound_int !== 1'b0)) begin
                pin_errors++;
                $display("ERR %0t: in reset bclk=%b lrclk=%b din=%b int=%b, expected 0 1 0 0",
                         $time, i2s_bclk, i2s_lrclk, i2s_din, sound_int);
            end
            rst_seen      <= 1'b1;
            bclk_q        <= 1'b0;
            lrclk_q       <= 1'b1;
            lr_at_rise    <= 1'b1;
            armed         <= 1'b0;
            word_sr       <= '0;
            run_len       <= 0;
            falls_in_word <= 0;
            fall_cnt      <= 0;
            pdm_phase     <= 0;
            window_done   <= 1'b0;
        end else begin
            bclk_q  <= i2s_bclk;
            lrclk_q <= i2s_lrclk;

            // Each bit-clock phase is a fixed number of clocks
            if (i2s_bclk != bclk_q) begin
                if (run_len != half_cycles) begin
                    pin_errors++;
                    $display("ERR %0t: bit clock phase of %0d cycles, expected %0d",
                             $time, run_len, half_cycles);
                end
                run_len <= 1;
            end else begin
                run_len <= run_len + 1;
            end

            // LRCLK moves only with a bit-clock fall
            if (lr_changed && !bclk_fell) begin
                pin_errors++;
                $display("ERR %0t: LRCLK changed without a bit-clock fall", $time);
            end
            if (bclk_fell) begin
                if (lr_changed) begin
                    if (falls_in_word + 1 != width) begin
                        pin_errors++;
                        $display("ERR %0t: LRCLK word of %0d bit periods, expected %0d",
                                 $time, falls_in_word + 1, width);
                    end
                    falls_in_word <= 0;
                end else begin
                    falls_in_word <= falls_in_word + 1;
                end
            end

            // Frames counted from the row's load
            if (lr_fell && fall_cnt < 1000) begin
                fall_cnt <= fall_cnt + 1;
            end

            // Data taken at bit-clock rise
            // A new LRCLK level here means this bit is the LSB of the old word
            if (bclk_rise) begin
                word_sr    <= word;
                lr_at_rise <= i2s_lrclk;
                if (i2s_lrclk != lr_at_rise) begin
                    if (!lr_at_rise) begin
                        if (armed && fall_cnt >= 1 && word !== exp_q.left) begin
                            word_errors++;
                            $display("ERR %0t: left word %h, expected %h",
                                     $time, word, exp_q.left);
                        end
                    end else if (armed && fall_cnt >= 2) begin
                        if (word !== exp_q.right) begin
                            word_errors++;
                            $display("ERR %0t: right word %h, expected %h",
                                     $time, word, exp_q.right);
                        end
                        frames_checked <= frames_checked + 1;
                    end
                end
            end

            // One sound_int sample per PDM step, output holds a whole step
            pdm_phase <= (pdm_phase == step_cycles - 1) ? 0 : pdm_phase + 1;
            if (armed && !window_done && fall_cnt >= 2 && pdm_phase == 0) begin
                if (pdm_steps == window_steps) begin
                    diff = ones * full_scale - window_steps * exp_offset_q;
                    if (diff > full_scale || diff < -full_scale) begin
                        pdm_errors++;
                        $display("ERR %0t: %0d ones in %0d PDM steps, expected %0.2f",
                                 $time, ones, window_steps,
                                 $itor(window_steps * exp_offset_q) / full_scale);
                    end
                    if (frames_checked < 2) begin
                        word_errors++;
                        $display("Fewer than two I2S frames were decoded for this row");
                    end
                    window_done <= 1'b1;
                end else begin
                    ones      <= ones + sound_int;
                    pdm_steps <= pdm_steps + 1;
                end
            end

            // New row wins over the updates above
            if (expect_load) begin
                armed          <= 1'b1;
                exp_q          <= exp_pair;
                exp_offset_q   <= exp_offset;
                fall_cnt       <= 0;
                frames_checked <= 0;
                pdm_steps      <= 0;
                ones           <= 0;
                window_done    <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_sound_out.sv ====
`timescale 1ns/1ps
`include "sound_cfg.svh"

module tb_sound_out;

    localparam int width        = `SOUND_SAMPLE_WIDTH;
    localparam int num_rows     = 10;
    localparam int frame_cycles = 4 * width * `SOUND_BCLK_DIV;
    localparam int fall_limit   = 2 * frame_cycles;
    localparam int window_limit = 1024 * `SOUND_DAC_FREQ_DIV + 4 * frame_cycles;

    // One stimulus row with the I2S words expected back unchanged
    typedef struct packed {
        audio_pkg::sample_t left;
        audio_pkg::sample_t right;
        audio_pkg::sample_t mono;
        logic               twice;
    } row_t;

    logic                      DAC_BCLK_SRC;
    logic                      RESET_n;
    logic                      sample_valid;
    audio_pkg::stereo_sample_t stereo_in;
    audio_pkg::sample_t        mono_in;
    logic                      i2s_bclk;
    logic                      i2s_lrclk;
    logic                      i2s_din;
    logic                      sound_int;

    // Expected values toward the checker
    logic                      expect_load;
    audio_pkg::stereo_sample_t exp_pair;
    int                        exp_offset;
    logic                      window_done;
    int                        pin_errors;
    int                        word_errors;
    int                        pdm_errors;
    int                        timeout_errors;
    row_t                      rows [num_rows];

    sound_out_top DUT (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .sample_valid (sample_valid),
        .stereo_in    (stereo_in),
        .mono_in      (mono_in),
        .i2s_bclk     (i2s_bclk),
        .i2s_lrclk    (i2s_lrclk),
        .i2s_din      (i2s_din),
        .sound_int    (sound_int)
    );

    sound_out_checker u_checker (
        .DAC_BCLK_SRC (DAC_BCLK_SRC),
        .RESET_n      (RESET_n),
        .i2s_bclk     (i2s_bclk),
        .i2s_lrclk    (i2s_lrclk),
        .i2s_din      (i2s_din),
        .sound_int    (sound_int),
        .expect_load  (expect_load),
        .exp_pair     (exp_pair),
        .exp_offset   (exp_offset),
        .window_done  (window_done),
        .pin_errors   (pin_errors),
        .word_errors  (word_errors),
        .pdm_errors   (pdm_errors)
    );

    initial begin
        DAC_BCLK_SRC = 1'b0;
        forever #4 DAC_BCLK_SRC = ~DAC_BCLK_SRC;
    end

    function automatic row_t make_row(input audio_pkg::sample_t l, input audio_pkg::sample_t r,
                                      input audio_pkg::sample_t m, input logic twice);
        row_t row;
        row.left  = l;
        row.right = r;
        row.mono  = m;
        row.twice = twice;
        return row;
    endfunction

    // Offset binary level is the signed sample moved up by half scale
    function automatic int mono_offset(input audio_pkg::sample_t s);
        return int'(s) + (1 << (width - 1));
    endfunction

    // Drive a pair for one clock from the falling edge
    task automatic strobe_pair(input audio_pkg::sample_t l, input audio_pkg::sample_t r,
                               input audio_pkg::sample_t m);
        stereo_in.left  = l;
        stereo_in.right = r;
        mono_in         = m;
        sample_valid    = 1'b1;
        @(negedge DAC_BCLK_SRC);
        sample_valid    = 1'b0;
    endtask

    task automatic wait_lrclk_fall();
        int   n;
        logic prev;
        logic found;
        n     = 0;
        found = 1'b0;
        prev  = i2s_lrclk;
        while (!found && n < fall_limit) begin
            @(negedge DAC_BCLK_SRC);
            found = prev & ~i2s_lrclk;
            prev  = i2s_lrclk;
            n++;
        end
        if (!found) begin
            timeout_errors++;
            $display("Timeout: no LRCLK falling edge within %0d clock cycles", fall_limit);
        end
    endtask

    task automatic wait_window_done();
        int n;
        n = 0;
        while (!window_done && n < window_limit) begin
            @(negedge DAC_BCLK_SRC);
            n++;
        end
        if (!window_done) begin
            timeout_errors++;
            $display("Timeout: PDM window not finished within %0d clock cycles", window_limit);
        end
    endtask

    // Strobe right after a frame boundary so both strobes share one frame
    task automatic run_row(input row_t row);
        wait_lrclk_fall();
        @(negedge DAC_BCLK_SRC);
        if (row.twice) begin
            strobe_pair(~row.left, ~row.right, row.mono);
            @(negedge DAC_BCLK_SRC);
        end
        strobe_pair(row.left, row.right, row.mono);
        exp_pair.left  = row.left;
        exp_pair.right = row.right;
        exp_offset     = mono_offset(row.mono);
        expect_load    = 1'b1;
        @(negedge DAC_BCLK_SRC);
        expect_load    = 1'b0;
        wait_lrclk_fall();
        wait_lrclk_fall();
        wait_window_done();
    endtask

    initial begin
        RESET_n        = 1'b0;
        sample_valid   = 1'b0;
        stereo_in      = '0;
        mono_in        = '0;
        expect_load    = 1'b0;
        exp_pair       = '0;
        exp_offset     = 0;
        timeout_errors = 0;
        void'($urandom(32'hf966));

        // Corner rows first and random ones after
        rows[0] = make_row(16'h0000, 16'h0000, 16'h0000, 1'b0);
        rows[1] = make_row(16'h7fff, 16'h7fff, 16'h7fff, 1'b0);
        rows[2] = make_row(16'h8000, 16'h8000, 16'h8000, 1'b0);
        rows[3] = make_row(16'haaaa, 16'h5555, 16'haaaa, 1'b0);
        rows[4] = make_row(16'h5555, 16'haaaa, 16'h5555, 1'b1);
        rows[5] = make_row(16'h7fff, 16'h8000, 16'hc000, 1'b1);
        for (int i = 6; i < num_rows; i++) begin
            rows[i] = make_row(audio_pkg::sample_t'($urandom), audio_pkg::sample_t'($urandom),
                               audio_pkg::sample_t'($urandom), 1'($urandom));
        end

        repeat (8) @(negedge DAC_BCLK_SRC);
        RESET_n = 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        repeat (4) @(negedge DAC_BCLK_SRC);

        $display("Error counts: pins %0d, words %0d, pdm %0d, timeouts %0d",
                 pin_errors, word_errors, pdm_errors, timeout_errors);
        if (pin_errors + word_errors + pdm_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
